// ==== bank_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module bank_ram (
   input  wire logic                 clk_i,
   input  wire logic                 rst_i,
   input  wire logic                 we_i,
   input  wire bram_chain_pkg::addr_t rd_addr_a_i,
   input  wire bram_chain_pkg::addr_t rd_addr_b_i,
   input  wire bram_chain_pkg::addr_t wr_addr_a_i,
   input  wire bram_chain_pkg::addr_t wr_addr_b_i,
   input  wire bram_chain_pkg::data_t wr_data_a_i,
   input  wire bram_chain_pkg::data_t wr_data_b_i,
   output bram_chain_pkg::data_t      rd_data_a_o,
   output bram_chain_pkg::data_t      rd_data_b_o
);
   import bram_chain_pkg::*;

   localparam int DEPTH = 2 ** ADDR_W;

   data_t mem [DEPTH];

   // Port B is written last so it wins on equal addresses
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[wr_addr_a_i] <= wr_data_a_i;
         mem[wr_addr_b_i] <= wr_data_b_i;
      end
   end

   // Registered reads, a read during a write sees the old word
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         rd_data_a_o <= '0;
         rd_data_b_o <= '0;
      end else begin
         rd_data_a_o <= mem[rd_addr_a_i];
         rd_data_b_o <= mem[rd_addr_b_i];
      end
   end

endmodule

`default_nettype wire

// ==== bram_chain_pkg.sv ====
`default_nettype none

package bram_chain_pkg;

   // ==============================
   // Widths and counts
   // ==============================
   localparam int DATA_W    = 12;
   localparam int ADDR_W    = 5;
   localparam int NUM_BANKS = 8;
   localparam int NUM_LANES = 2 * NUM_BANKS;
   localparam int WB_DELAY  = 7;

   // Bank index width, the pair permutations below rely on it being 3
   localparam int BANK_W    = $clog2(NUM_BANKS);

   // ==============================
   // Vector types
   // ==============================
   typedef logic [DATA_W-1:0]           data_t;
   typedef logic [ADDR_W-1:0]           addr_t;

   // Lane k sits at slice k, lanes 0-7 are the A side
   typedef logic [NUM_LANES*DATA_W-1:0] data_lanes_t;
   typedef logic [NUM_LANES*ADDR_W-1:0] addr_lanes_t;

   typedef logic [NUM_BANKS-1:0]        bank_mask_t;

   // Transform length as seen by the bank routing
   typedef enum logic [1:0] {
      LEN_DIRECT = 2'd0,
      LEN_32     = 2'd1,
      LEN_64     = 2'd2,
      LEN_128    = 2'd3
   } len_mode_t;

endpackage

`default_nettype wire

// ==== bram_chain_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module bram_chain_top (
   input  wire logic                        clk_i,
   input  wire logic                        rst_i,
   input  wire logic                        load_i,
   input  wire logic                        chain_i,
   input  wire logic                        write_i,
   input  wire bram_chain_pkg::bank_mask_t  we_i,
   input  wire bram_chain_pkg::len_mode_t   len_mode_i,
   input  wire bram_chain_pkg::data_t       load_data_a_i,
   input  wire bram_chain_pkg::data_t       load_data_b_i,
   input  wire bram_chain_pkg::addr_t       load_addr_a_i,
   input  wire bram_chain_pkg::addr_t       load_addr_b_i,
   input  wire bram_chain_pkg::addr_lanes_t gen_addr_i,
   input  wire bram_chain_pkg::data_lanes_t wb_data_i,
   output bram_chain_pkg::data_lanes_t      rd_data_o
);
   import bram_chain_pkg::*;

   logic [NUM_BANKS*ADDR_W-1:0] rd_addr_a;
   logic [NUM_BANKS*ADDR_W-1:0] rd_addr_b;
   logic [NUM_BANKS*ADDR_W-1:0] wr_addr_a;
   logic [NUM_BANKS*ADDR_W-1:0] wr_addr_b;
   logic [NUM_BANKS*DATA_W-1:0] wr_data_a;
   logic [NUM_BANKS*DATA_W-1:0] wr_data_b;
   bank_mask_t                  wr_en;
   addr_lanes_t                 dly_addr;

   read_addr_router u_read_addr_router (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .load_i        (load_i),
      .chain_i       (chain_i),
      .len_mode_i    (len_mode_i),
      .load_addr_a_i (load_addr_a_i),
      .load_addr_b_i (load_addr_b_i),
      .gen_addr_i    (gen_addr_i),
      .rd_addr_a_o   (rd_addr_a),
      .rd_addr_b_o   (rd_addr_b)
   );

   wb_addr_delay u_wb_addr_delay (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .chain_i    (chain_i),
      .gen_addr_i (gen_addr_i),
      .dly_addr_o (dly_addr)
   );

   write_port_ctrl u_write_port_ctrl (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .load_i        (load_i),
      .write_i       (write_i),
      .we_i          (we_i),
      .load_data_a_i (load_data_a_i),
      .load_data_b_i (load_data_b_i),
      .load_addr_a_i (load_addr_a_i),
      .load_addr_b_i (load_addr_b_i),
      .wb_data_i     (wb_data_i),
      .dly_addr_i    (dly_addr),
      .wr_data_a_o   (wr_data_a),
      .wr_data_b_o   (wr_data_b),
      .wr_addr_a_o   (wr_addr_a),
      .wr_addr_b_o   (wr_addr_b),
      .wr_en_o       (wr_en)
   );

   // ==============================
   // Banks, port A on lane b and port B on lane 8+b
   // ==============================
   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      bank_ram u_bank_ram (
         .clk_i       (clk_i),
         .rst_i       (rst_i),
         .we_i        (wr_en[b]),
         .rd_addr_a_i (rd_addr_a[b*ADDR_W +: ADDR_W]),
         .rd_addr_b_i (rd_addr_b[b*ADDR_W +: ADDR_W]),
         .wr_addr_a_i (wr_addr_a[b*ADDR_W +: ADDR_W]),
         .wr_addr_b_i (wr_addr_b[b*ADDR_W +: ADDR_W]),
         .wr_data_a_i (wr_data_a[b*DATA_W +: DATA_W]),
         .wr_data_b_i (wr_data_b[b*DATA_W +: DATA_W]),
         .rd_data_a_o (rd_data_o[b*DATA_W +: DATA_W]),
         .rd_data_b_o (rd_data_o[(b+NUM_BANKS)*DATA_W +: DATA_W])
      );
   end

endmodule

`default_nettype wire

// ==== flist.f ====
bram_chain_pkg.sv
bank_ram.sv
read_addr_router.sv
wb_addr_delay.sv
write_port_ctrl.sv
bram_chain_top.sv
tb_checker.sv
tb_top.sv

// ==== read_addr_router.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_addr_router (
   input  wire logic                                              clk_i,
   input  wire logic                                              rst_i,
   input  wire logic                                              load_i,
   input  wire logic                                              chain_i,
   input  wire bram_chain_pkg::len_mode_t                         len_mode_i,
   input  wire bram_chain_pkg::addr_t                             load_addr_a_i,
   input  wire bram_chain_pkg::addr_t                             load_addr_b_i,
   input  wire bram_chain_pkg::addr_lanes_t                       gen_addr_i,
   output logic [bram_chain_pkg::NUM_BANKS*bram_chain_pkg::ADDR_W-1:0] rd_addr_a_o,
   output logic [bram_chain_pkg::NUM_BANKS*bram_chain_pkg::ADDR_W-1:0] rd_addr_b_o
);
   import bram_chain_pkg::*;

   logic [NUM_BANKS*ADDR_W-1:0] addr_a_d;
   logic [NUM_BANKS*ADDR_W-1:0] addr_b_d;

   // Lane feeding a bank port for the given length mode
   function automatic int unsigned lane_sel(len_mode_t mode, int unsigned bank, logic port_b);
      logic [BANK_W-1:0] b;
      logic [BANK_W-1:0] pair;
      b = BANK_W'(bank);
      case (mode)
         LEN_32:  pair = {b[0], b[2], b[1]};
         LEN_64:  pair = {b[1], b[2], b[0]};
         default: pair = b;
      endcase
      if (mode == LEN_DIRECT) begin
         lane_sel = port_b ? bank + NUM_BANKS : bank;
      end else begin
         // Even lane of the pair to port A, odd lane to port B
         lane_sel = 2 * int'(pair) + int'(port_b);
      end
   endfunction

   // ==============================
   // Next read addresses
   // ==============================
   always_comb begin
      addr_a_d = rd_addr_a_o;
      addr_b_d = rd_addr_b_o;
      if (load_i) begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            addr_a_d[b*ADDR_W +: ADDR_W] = load_addr_a_i;
            addr_b_d[b*ADDR_W +: ADDR_W] = load_addr_b_i;
         end
      end else if (chain_i) begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            addr_a_d[b*ADDR_W +: ADDR_W] =
               gen_addr_i[lane_sel(len_mode_i, b, 1'b0)*ADDR_W +: ADDR_W];
            addr_b_d[b*ADDR_W +: ADDR_W] =
               gen_addr_i[lane_sel(len_mode_i, b, 1'b1)*ADDR_W +: ADDR_W];
         end
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         rd_addr_a_o <= '0;
         rd_addr_b_o <= '0;
      end else begin
         rd_addr_a_o <= addr_a_d;
         rd_addr_b_o <= addr_b_d;
      end
   end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_top -f flist.f -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Checks failed" "$LOG"; then
   exit 1
fi
exit 0

// ==== tb_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_checker (
   input  wire logic                        clk_i,
   input  wire logic                        rst_i,
   input  wire logic                        load_i,
   input  wire logic                        chain_i,
   input  wire logic                        write_i,
   input  wire bram_chain_pkg::bank_mask_t  we_i,
   input  wire bram_chain_pkg::len_mode_t   len_mode_i,
   input  wire bram_chain_pkg::data_t       load_data_a_i,
   input  wire bram_chain_pkg::data_t       load_data_b_i,
   input  wire bram_chain_pkg::addr_t       load_addr_a_i,
   input  wire bram_chain_pkg::addr_t       load_addr_b_i,
   input  wire bram_chain_pkg::addr_lanes_t gen_addr_i,
   input  wire bram_chain_pkg::data_lanes_t wb_data_i,
   input  wire bram_chain_pkg::data_lanes_t rd_data_i,
   output logic                             busy_o,
   output int                               check_cnt_o,
   output int                               error_cnt_o
);
   import bram_chain_pkg::*;

   // Pair taken by each bank in the two folded length modes
   localparam int PAIR_32 [NUM_BANKS] = '{0, 4, 1, 5, 2, 6, 3, 7};
   localparam int PAIR_64 [NUM_BANKS] = '{0, 1, 4, 5, 2, 3, 6, 7};

   data_t       mem [NUM_BANKS][2**ADDR_W];
   // Set once a word holds a written value
   bit          known [NUM_BANKS][2**ADDR_W];
   addr_t       raddr [NUM_LANES];
   data_t       exp_rd [NUM_LANES];
   bit          exp_known [NUM_LANES];
   addr_t       waddr [NUM_LANES];
   data_t       wdata [NUM_LANES];
   bank_mask_t  wen;
   addr_lanes_t dly_q [$];
   logic [1:0]  rd_pend;

   function automatic int src_lane(len_mode_t mode, int bank, int port_b);
      int pair;
      case (mode)
         LEN_DIRECT: return bank + port_b * NUM_BANKS;
         LEN_32:     pair = PAIR_32[bank];
         LEN_64:     pair = PAIR_64[bank];
         default:    pair = bank;
      endcase
      return 2 * pair + port_b;
   endfunction

   assign busy_o = |rd_pend;

   // ==============================
   // Reference model stepped on each edge
   // ==============================
   always @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         wen = '0;
         rd_pend = '0;
         check_cnt_o = 0;
         error_cnt_o = 0;
         dly_q = {};
         for (int k = 0; k < NUM_LANES; k++) begin
            raddr[k] = '0;
         end
         for (int b = 0; b < NUM_BANKS; b++) begin
            for (int i = 0; i < 2**ADDR_W; i++) begin
               known[b][i] = 1'b0;
            end
         end
         for (int i = 0; i < WB_DELAY; i++) begin
            dly_q.push_back('0);
         end
      end else begin
         // Output now holds the word read at the previous edge
         if (rd_pend[1]) begin
            for (int k = 0; k < NUM_LANES; k++) begin
               if (exp_known[k]) begin
                  check_cnt_o++;
                  if (rd_data_i[k*DATA_W +: DATA_W] !== exp_rd[k]) begin
                     error_cnt_o++;
                     $display("ERROR rd_data_o lane %0d: expected 0x%h, actual 0x%h",
                              k, exp_rd[k], rd_data_i[k*DATA_W +: DATA_W]);
                  end
               end
            end
         end
         // Read before the pending write lands
         for (int k = 0; k < NUM_LANES; k++) begin
            exp_rd[k] = mem[k % NUM_BANKS][raddr[k]];
            exp_known[k] = known[k % NUM_BANKS][raddr[k]];
         end
         for (int b = 0; b < NUM_BANKS; b++) begin
            if (wen[b]) begin
               mem[b][waddr[b]] = wdata[b];
               mem[b][waddr[b+NUM_BANKS]] = wdata[b+NUM_BANKS];
               known[b][waddr[b]] = 1'b1;
               known[b][waddr[b+NUM_BANKS]] = 1'b1;
            end
         end
         if (load_i) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
               waddr[b] = load_addr_a_i;
               waddr[b+NUM_BANKS] = load_addr_b_i;
               wdata[b] = load_data_a_i;
               wdata[b+NUM_BANKS] = load_data_b_i;
            end
            wen = we_i;
         end else if (write_i) begin
            for (int k = 0; k < NUM_LANES; k++) begin
               waddr[k] = dly_q[0][k*ADDR_W +: ADDR_W];
               wdata[k] = wb_data_i[k*DATA_W +: DATA_W];
            end
            wen = we_i;
         end else begin
            wen = '0;
         end
         if (load_i) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
               raddr[b] = load_addr_a_i;
               raddr[b+NUM_BANKS] = load_addr_b_i;
            end
         end else if (chain_i) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
               raddr[b] = gen_addr_i[src_lane(len_mode_i, b, 0)*ADDR_W +: ADDR_W];
               raddr[b+NUM_BANKS] = gen_addr_i[src_lane(len_mode_i, b, 1)*ADDR_W +: ADDR_W];
            end
         end
         if (chain_i) begin
            dly_q.push_back(gen_addr_i);
            void'(dly_q.pop_front());
         end
         rd_pend = {rd_pend[0], chain_i | load_i};
      end
   end

endmodule

`default_nettype wire

// ==== tb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_top;
   import bram_chain_pkg::*;

   localparam int DRAIN_LIMIT = 20;

   logic        clk_i;
   logic        rst_i;
   logic        load_i;
   logic        chain_i;
   logic        write_i;
   bank_mask_t  we_i;
   len_mode_t   len_mode_i;
   data_t       load_data_a_i;
   data_t       load_data_b_i;
   addr_t       load_addr_a_i;
   addr_t       load_addr_b_i;
   addr_lanes_t gen_addr_i;
   data_lanes_t wb_data_i;
   data_lanes_t rd_data_o;
   logic        busy;
   int          check_cnt;
   int          error_cnt;
   logic [31:0] rng_state = 32'h3e68_62e3;
   int          test_num = 0;
   int          base_checks = 0;
   int          base_errors = 0;
   bit          ok = 1'b1;

   bram_chain_top u_bram_chain_top (.*);

   tb_checker u_checker (
      .clk_i (clk_i), .rst_i (rst_i), .load_i (load_i), .chain_i (chain_i),
      .write_i (write_i), .we_i (we_i), .len_mode_i (len_mode_i),
      .load_data_a_i (load_data_a_i), .load_data_b_i (load_data_b_i),
      .load_addr_a_i (load_addr_a_i), .load_addr_b_i (load_addr_b_i),
      .gen_addr_i (gen_addr_i), .wb_data_i (wb_data_i), .rd_data_i (rd_data_o),
      .busy_o (busy), .check_cnt_o (check_cnt), .error_cnt_o (error_cnt)
   );

   always #20 clk_i = ~clk_i;

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // Take the upper LCG bits that have the longest period
   function automatic logic [31:0] rand_bits(int n);
      return next_rand() >> (32 - n);
   endfunction

   function automatic addr_t pick_addr_b(addr_t a);
      if (rand_bits(2) == 0) return a;
      return addr_t'(rand_bits(ADDR_W));
   endfunction

   task automatic next_cycle();
      @(posedge clk_i);
      #2;
   endtask

   task automatic drive(input bit ld, input bit ch, input bit wr, input bank_mask_t mask,
                        input addr_t a, input addr_t b);
      load_i = ld;
      chain_i = ch;
      write_i = wr;
      we_i = mask;
      load_addr_a_i = a;
      load_addr_b_i = b;
      load_data_a_i = data_t'(rand_bits(DATA_W));
      load_data_b_i = data_t'(rand_bits(DATA_W));
      for (int k = 0; k < NUM_LANES; k++) begin
         gen_addr_i[k*ADDR_W +: ADDR_W] = addr_t'(rand_bits(ADDR_W));
         wb_data_i[k*DATA_W +: DATA_W] = data_t'(rand_bits(DATA_W));
      end
      next_cycle();
   endtask

   task automatic end_test(input string name);
      int waited;
      waited = 0;
      load_i = 1'b0;
      chain_i = 1'b0;
      write_i = 1'b0;
      while (busy && waited < DRAIN_LIMIT) begin
         next_cycle();
         waited++;
      end
      if (busy) begin
         $display("Timeout: read checks still pending after %0d cycles", waited);
         ok = 1'b0;
      end
      test_num++;
      $display("Test %0d %s: %0d checks, %0d errors", test_num, name,
               check_cnt - base_checks, error_cnt - base_errors);
      base_checks = check_cnt;
      base_errors = error_cnt;
   endtask

   initial begin
      addr_t a;
      clk_i = 1'b0;
      rst_i = 1'b1;
      load_i = 1'b0;
      chain_i = 1'b0;
      write_i = 1'b0;
      we_i = '0;
      len_mode_i = LEN_DIRECT;
      load_data_a_i = '0;
      load_data_b_i = '0;
      load_addr_a_i = '0;
      load_addr_b_i = '0;
      gen_addr_i = '0;
      wb_data_i = '0;
      repeat (2) @(posedge clk_i);
      #2 rst_i = 1'b0;

      // Fill every word of every bank first
      for (int i = 0; i < 16; i++) begin
         drive(1'b1, 1'b0, 1'b0, '1, addr_t'(2 * i), addr_t'(2 * i + 1));
      end
      repeat (20) begin
         a = addr_t'(rand_bits(ADDR_W));
         drive(1'b1, 1'b0, 1'b0, '1, a, pick_addr_b(a));
      end
      // Delay line still zero here
      repeat (2) drive(1'b0, 1'b0, 1'b1, '1, '0, '0);
      repeat (30) drive(1'b0, 1'b1, 1'b0, '0, '0, '0);
      end_test("load_direct");

      if (ok) begin
         for (int m = 1; m < 4; m++) begin
            len_mode_i = len_mode_t'(m);
            repeat (20) drive(1'b0, 1'b1, 1'b0, '0, '0, '0);
         end
         end_test("length_modes");
      end
      if (ok) begin
         len_mode_i = LEN_DIRECT;
         repeat (10) drive(1'b0, 1'b1, 1'b0, '0, '0, '0);
         repeat (20) drive(1'b0, 1'b1, 1'b1, '1, '0, '0);
         repeat (20) drive(1'b0, 1'b1, 1'b0, '0, '0, '0);
         end_test("write_back");
      end
      if (ok) begin
         repeat (20) begin
            a = addr_t'(rand_bits(ADDR_W));
            drive(1'b1, 1'b0, 1'b0, bank_mask_t'(rand_bits(NUM_BANKS)), a, pick_addr_b(a));
         end
         repeat (20) drive(1'b0, 1'b1, 1'b1, bank_mask_t'(rand_bits(NUM_BANKS)), '0, '0);
         repeat (20) drive(1'b0, 1'b1, 1'b0, '0, '0, '0);
         end_test("bank_mask");
      end
      if (ok) begin
         repeat (150) begin
            len_mode_i = len_mode_t'(rand_bits(2));
            a = addr_t'(rand_bits(ADDR_W));
            drive(bit'(rand_bits(1)), bit'(rand_bits(1)), bit'(rand_bits(1)),
                  bank_mask_t'(rand_bits(NUM_BANKS)), a, pick_addr_b(a));
         end
         end_test("random_mix");
      end

      $display("Totals: %0d tests, %0d checks, %0d errors", test_num, check_cnt, error_cnt);
      if (!ok || error_cnt != 0 || check_cnt == 0) begin
         $display("Checks failed");
      end else begin
         $display("All checks passed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== wb_addr_delay.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_addr_delay (
   input  wire logic                        clk_i,
   input  wire logic                        rst_i,
   input  wire logic                        chain_i,
   input  wire bram_chain_pkg::addr_lanes_t gen_addr_i,
   output bram_chain_pkg::addr_lanes_t      dly_addr_o
);
   import bram_chain_pkg::*;

   addr_lanes_t stage_q [WB_DELAY];

   // Shifts once per chain step, idle cycles do not count
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         for (int i = 0; i < WB_DELAY; i++) begin
            stage_q[i] <= '0;
         end
      end else if (chain_i) begin
         stage_q[0] <= gen_addr_i;
         for (int i = 1; i < WB_DELAY; i++) begin
            stage_q[i] <= stage_q[i-1];
         end
      end
   end

   // Oldest addresses, the write-back targets
   assign dly_addr_o = stage_q[WB_DELAY-1];

endmodule

`default_nettype wire

// ==== write_port_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module write_port_ctrl (
   input  wire logic                                              clk_i,
   input  wire logic                                              rst_i,
   input  wire logic                                              load_i,
   input  wire logic                                              write_i,
   input  wire bram_chain_pkg::bank_mask_t                        we_i,
   input  wire bram_chain_pkg::data_t                             load_data_a_i,
   input  wire bram_chain_pkg::data_t                             load_data_b_i,
   input  wire bram_chain_pkg::addr_t                             load_addr_a_i,
   input  wire bram_chain_pkg::addr_t                             load_addr_b_i,
   input  wire bram_chain_pkg::data_lanes_t                       wb_data_i,
   input  wire bram_chain_pkg::addr_lanes_t                       dly_addr_i,
   output logic [bram_chain_pkg::NUM_BANKS*bram_chain_pkg::DATA_W-1:0] wr_data_a_o,
   output logic [bram_chain_pkg::NUM_BANKS*bram_chain_pkg::DATA_W-1:0] wr_data_b_o,
   output logic [bram_chain_pkg::NUM_BANKS*bram_chain_pkg::ADDR_W-1:0] wr_addr_a_o,
   output logic [bram_chain_pkg::NUM_BANKS*bram_chain_pkg::ADDR_W-1:0] wr_addr_b_o,
   output bram_chain_pkg::bank_mask_t                                  wr_en_o
);
   import bram_chain_pkg::*;

   localparam int DATA_SIDE_W = NUM_BANKS * DATA_W;
   localparam int ADDR_SIDE_W = NUM_BANKS * ADDR_W;

   // ==============================
   // Write port registers
   // ==============================
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         wr_data_a_o <= '0;
         wr_data_b_o <= '0;
         wr_addr_a_o <= '0;
         wr_addr_b_o <= '0;
         wr_en_o     <= '0;
      end else if (load_i) begin
         // Broadcast the load word pair to every bank
         wr_data_a_o <= {NUM_BANKS{load_data_a_i}};
         wr_data_b_o <= {NUM_BANKS{load_data_b_i}};
         wr_addr_a_o <= {NUM_BANKS{load_addr_a_i}};
         wr_addr_b_o <= {NUM_BANKS{load_addr_b_i}};
         wr_en_o     <= we_i;
      end else if (write_i) begin
         // Lanes 0-7 go to port A, lanes 8-15 to port B
         wr_data_a_o <= wb_data_i[DATA_SIDE_W-1:0];
         wr_data_b_o <= wb_data_i[2*DATA_SIDE_W-1:DATA_SIDE_W];
         wr_addr_a_o <= dly_addr_i[ADDR_SIDE_W-1:0];
         wr_addr_b_o <= dly_addr_i[2*ADDR_SIDE_W-1:ADDR_SIDE_W];
         wr_en_o     <= we_i;
      end else begin
         wr_data_a_o <= '0;
         wr_data_b_o <= '0;
         wr_en_o     <= '0;
      end
   end

endmodule

`default_nettype wire
